//--- source/fsab_mem_defines.svh
`ifndef FSAB_MEM_DEFINES_SVH
`define FSAB_MEM_DEFINES_SVH

// FSAB bus field widths
`define FSAB_DATA_W 64
`define FSAB_MASK_W 8
`define FSAB_ADDR_W 32
`define FSAB_LEN_W 4
`define FSAB_DID_W 4

// Burst and flow control limits
`define FSAB_LEN_MAX 8
`define FSAB_INITIAL_CREDITS 4

// Every outstanding request may be a full-length write
`define IDFIF_DEPTH (`FSAB_INITIAL_CREDITS * `FSAB_LEN_MAX)

// Backing store, 256 words of 64 bits
`define MEM_WORDS_LOG2 8

`endif

//--- source/fsab_mem_pkg.sv
`default_nettype none

`include "fsab_mem_defines.svh"

package fsab_mem_pkg;

	typedef logic [`FSAB_DATA_W-1:0] fsab_data_t;
	typedef logic [`FSAB_MASK_W-1:0] fsab_mask_t;	// One bit per byte lane
	typedef logic [`FSAB_ADDR_W-1:0] fsab_addr_t;	// Byte address
	typedef logic [`FSAB_LEN_W-1:0] fsab_len_t;	// Beats, 1 to 8
	typedef logic [`FSAB_DID_W-1:0] fsab_did_t;
	typedef logic fsab_mode_t;

	localparam fsab_mode_t FSAB_READ = 1'b0;
	localparam fsab_mode_t FSAB_WRITE = 1'b1;

	typedef logic [`MEM_WORDS_LOG2-1:0] mem_index_t;

	typedef enum logic [1:0] {
		MEM_IDLE,	// Waiting for a complete request
		MEM_WRITE,	// One beat per cycle into memory
		MEM_READ,	// One beat per cycle to the result queue
		MEM_DRAIN	// Read response still leaving on fsabi
	} mem_state_t;

endpackage

`default_nettype wire

//--- source/fsab_mem_if.sv
`timescale 1ns/100ps
`default_nettype none

// Request head from decode to execute
interface fsab_req_if import fsab_mem_pkg::*; ();
	logic hdr_valid;	// Complete request at queue head
	fsab_mode_t mode;
	fsab_did_t did;
	fsab_did_t subdid;
	fsab_addr_t addr;
	fsab_len_t len;
	fsab_data_t beat_data;	// Head of the data FIFO
	fsab_mask_t beat_mask;
	logic hdr_pop;
	logic beat_pop;

	modport decode (output hdr_valid, mode, did, subdid, addr, len, beat_data, beat_mask,
		input hdr_pop, beat_pop);
	modport execute (input hdr_valid, mode, did, subdid, addr, len, beat_data, beat_mask,
		output hdr_pop, beat_pop);
endinterface

// Read beats from execute to the result queue
interface fsab_rsp_if import fsab_mem_pkg::*; ();
	logic push;
	fsab_did_t did;
	fsab_did_t subdid;
	fsab_data_t data;
	logic last;	// Final beat of the response
	logic room;	// Space for a full burst
	logic done;	// Last beat is on fsabi

	modport execute (output push, did, subdid, data, last, input room, done);
	modport result (input push, did, subdid, data, last, output room, done);
endinterface

`default_nettype wire

//--- source/fsab_req_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsab_mem_defines.svh"

module fsab_req_decode import fsab_mem_pkg::*; (
	input wire logic clk0_tb,
	input wire logic rst0_tb,
	input wire logic fsabo_valid,
	input wire fsab_mode_t fsabo_mode,
	input wire fsab_did_t fsabo_did,
	input wire fsab_did_t fsabo_subdid,
	input wire fsab_addr_t fsabo_addr,
	input wire fsab_len_t fsabo_len,
	input wire fsab_data_t fsabo_data,
	input wire fsab_mask_t fsabo_mask,
	fsab_req_if.decode req
);
	localparam int HDR_AW = $clog2(`FSAB_INITIAL_CREDITS);
	localparam int BEAT_AW = $clog2(`IDFIF_DEPTH);
	localparam int CNT_W = $clog2(`FSAB_INITIAL_CREDITS + 1);
	localparam int HDR_W = $bits(fsab_mode_t) + 2 * $bits(fsab_did_t) + $bits(fsab_addr_t)
		+ $bits(fsab_len_t);
	localparam int BEAT_W = $bits(fsab_data_t) + $bits(fsab_mask_t);

	logic [HDR_W-1:0] hdr_mem [`FSAB_INITIAL_CREDITS];
	logic [BEAT_W-1:0] beat_mem [`IDFIF_DEPTH];
	logic [HDR_AW:0] hdr_wptr_q, hdr_rptr_q;	// Extra bit tells full from empty
	logic [BEAT_AW:0] beat_wptr_q, beat_rptr_q;
	fsab_len_t rem_q;	// Write beats still to come
	logic [CNT_W-1:0] cnt_q;	// Complete requests queued
	logic hdr_cycle;
	logic hdr_push;
	logic beat_push;
	logic req_done;
	logic hdr_full;
	logic beat_empty;

	assign hdr_cycle = fsabo_valid && (rem_q == '0);
	assign hdr_push = hdr_cycle;
	assign beat_push = fsabo_valid && ((rem_q != '0) || (fsabo_mode == FSAB_WRITE));

	// Read header or the final write beat completes a request
	assign req_done = (hdr_cycle && (fsabo_mode == FSAB_READ || fsabo_len == fsab_len_t'(1)))
		|| (fsabo_valid && rem_q == fsab_len_t'(1));

	assign hdr_full = (hdr_wptr_q[HDR_AW] != hdr_rptr_q[HDR_AW])
		&& (hdr_wptr_q[HDR_AW-1:0] == hdr_rptr_q[HDR_AW-1:0]);
	assign beat_empty = (beat_wptr_q == beat_rptr_q);

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			rem_q <= '0;
			cnt_q <= '0;
			hdr_wptr_q <= '0;
			hdr_rptr_q <= '0;
			beat_wptr_q <= '0;
			beat_rptr_q <= '0;
		end else begin
			if (hdr_cycle && fsabo_mode == FSAB_WRITE)
				rem_q <= fsabo_len - fsab_len_t'(1);
			else if (fsabo_valid && rem_q != '0)
				rem_q <= rem_q - fsab_len_t'(1);
			cnt_q <= cnt_q + CNT_W'(req_done) - CNT_W'(req.hdr_pop);
			if (hdr_push)
				hdr_wptr_q <= hdr_wptr_q + 1'b1;
			if (req.hdr_pop)
				hdr_rptr_q <= hdr_rptr_q + 1'b1;
			if (beat_push)
				beat_wptr_q <= beat_wptr_q + 1'b1;
			if (req.beat_pop)
				beat_rptr_q <= beat_rptr_q + 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_push)
			hdr_mem[hdr_wptr_q[HDR_AW-1:0]] <= {fsabo_mode, fsabo_did, fsabo_subdid,
				fsabo_addr, fsabo_len};
		if (beat_push)
			beat_mem[beat_wptr_q[BEAT_AW-1:0]] <= {fsabo_data, fsabo_mask};
	end

	assign req.hdr_valid = (cnt_q != '0);
	assign {req.mode, req.did, req.subdid, req.addr, req.len} = hdr_mem[hdr_rptr_q[HDR_AW-1:0]];
	assign {req.beat_data, req.beat_mask} = beat_mem[beat_rptr_q[BEAT_AW-1:0]];

	// A fifth outstanding request means the master ignored its credits
	a_hdr_no_overflow: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		hdr_push |-> !hdr_full);

	a_beat_no_underflow: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		req.beat_pop |-> !beat_empty);

endmodule

`default_nettype wire

//--- source/fsab_mem_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsab_mem_defines.svh"

module fsab_mem_execute import fsab_mem_pkg::*; (
	input wire logic clk0_tb,
	input wire logic rst0_tb,
	fsab_req_if.execute req,
	fsab_rsp_if.execute rsp,
	output logic fsabo_credit
);
	localparam int MEM_WORDS = 2 ** `MEM_WORDS_LOG2;

	fsab_data_t mem [MEM_WORDS];
	mem_state_t state_q, state_d;
	fsab_len_t len_rem_q;	// Beats left in the current request
	mem_index_t idx_q;	// Word of the current beat
	fsab_did_t did_q, subdid_q;
	logic credit_q;
	logic hdr_pop;
	logic beat_pop;
	logic push;
	logic last;
	fsab_data_t cur_word;
	fsab_data_t merged;

	assign cur_word = mem[idx_q];

	always_comb begin
		merged = cur_word;
		for (int b = 0; b < $bits(fsab_mask_t); b++) begin
			if (req.beat_mask[b])
				merged[8*b +: 8] = req.beat_data[8*b +: 8];
		end
	end

	always_comb begin
		state_d = state_q;
		hdr_pop = 1'b0;
		beat_pop = 1'b0;
		push = 1'b0;
		last = 1'b0;
		case (state_q)
			MEM_IDLE: begin
				if (req.hdr_valid && req.mode == FSAB_WRITE) begin
					hdr_pop = 1'b1;
					state_d = MEM_WRITE;
				end else if (req.hdr_valid && rsp.room) begin	// Reads need queue space
					hdr_pop = 1'b1;
					state_d = MEM_READ;
				end
			end
			MEM_WRITE: begin
				beat_pop = 1'b1;
				if (len_rem_q == fsab_len_t'(1))
					state_d = MEM_IDLE;
			end
			MEM_READ: begin
				push = 1'b1;
				last = (len_rem_q == fsab_len_t'(1));
				if (last)
					state_d = MEM_DRAIN;
			end
			MEM_DRAIN: begin
				if (rsp.done)
					state_d = MEM_IDLE;
			end
			default: state_d = MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			state_q <= MEM_IDLE;
			len_rem_q <= '0;
			idx_q <= '0;
			credit_q <= 1'b0;
		end else begin
			state_q <= state_d;
			credit_q <= (beat_pop && len_rem_q == fsab_len_t'(1))
				|| (state_q == MEM_DRAIN && rsp.done);
			if (hdr_pop) begin
				len_rem_q <= req.len;
				idx_q <= req.addr[3 +: `MEM_WORDS_LOG2];	// Byte address to word
			end else if (beat_pop || push) begin
				len_rem_q <= len_rem_q - fsab_len_t'(1);
				idx_q <= idx_q + mem_index_t'(1);
			end
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_pop) begin
			did_q <= req.did;
			subdid_q <= req.subdid;
		end
		if (beat_pop)
			mem[idx_q] <= merged;
	end

	assign req.hdr_pop = hdr_pop;
	assign req.beat_pop = beat_pop;
	assign rsp.push = push;
	assign rsp.last = last;
	assign rsp.data = cur_word;
	assign rsp.did = did_q;
	assign rsp.subdid = subdid_q;
	assign fsabo_credit = credit_q;

	// At least one idle cycle separates the ends of two requests
	a_credit_single: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		fsabo_credit |=> !fsabo_credit);

endmodule

`default_nettype wire

//--- source/fsab_rsp_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsab_mem_defines.svh"

module fsab_rsp_result import fsab_mem_pkg::*; (
	input wire logic clk0_tb,
	input wire logic rst0_tb,
	fsab_rsp_if.result rsp,
	output logic fsabi_valid,
	output fsab_did_t fsabi_did,
	output fsab_did_t fsabi_subdid,
	output fsab_data_t fsabi_data
);
	localparam int DEPTH = `FSAB_LEN_MAX;
	localparam int AW = $clog2(DEPTH);
	localparam int RSP_W = 2 * $bits(fsab_did_t) + 1 + $bits(fsab_data_t);
	localparam logic [AW:0] ROOM_LIMIT = (AW + 1)'(DEPTH - `FSAB_LEN_MAX);

	logic [RSP_W-1:0] fifo_mem [DEPTH];
	logic [AW:0] wptr_q, rptr_q;
	logic [AW:0] used;
	logic [AW:0] lasts_q;	// Complete responses in the queue
	logic pop;
	logic head_last;
	fsab_did_t head_did, head_subdid;
	fsab_data_t head_data;
	logic valid_q;
	logic last_out_q;	// Beat on fsabi ends its response

	assign used = wptr_q - rptr_q;
	assign rsp.room = (used <= ROOM_LIMIT);

	// Oldest queued response is whole once any last flag is queued
	assign pop = (lasts_q != '0);
	assign {head_did, head_subdid, head_last, head_data} = fifo_mem[rptr_q[AW-1:0]];

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			wptr_q <= '0;
			rptr_q <= '0;
			lasts_q <= '0;
			valid_q <= 1'b0;
			last_out_q <= 1'b0;
		end else begin
			if (rsp.push)
				wptr_q <= wptr_q + 1'b1;
			if (pop)
				rptr_q <= rptr_q + 1'b1;
			lasts_q <= lasts_q + (AW + 1)'(rsp.push && rsp.last)
				- (AW + 1)'(pop && head_last);
			valid_q <= pop;
			last_out_q <= pop && head_last;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (rsp.push)
			fifo_mem[wptr_q[AW-1:0]] <= {rsp.did, rsp.subdid, rsp.last, rsp.data};
		if (pop) begin
			fsabi_did <= head_did;
			fsabi_subdid <= head_subdid;
			fsabi_data <= head_data;
		end
	end

	assign fsabi_valid = valid_q;
	assign rsp.done = valid_q && last_out_q;

	// Mid-response beats are followed by another beat of the same requester
	a_ids_stable: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid && !last_out_q |=> fsabi_valid && $stable(fsabi_did)
			&& $stable(fsabi_subdid));

endmodule

`default_nettype wire

//--- source/fsab_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module fsab_mem_top import fsab_mem_pkg::*; (
	input wire logic clk0_tb,
	input wire logic rst0_tb,
	input wire logic fsabo_valid,
	input wire fsab_mode_t fsabo_mode,
	input wire fsab_did_t fsabo_did,
	input wire fsab_did_t fsabo_subdid,
	input wire fsab_addr_t fsabo_addr,
	input wire fsab_len_t fsabo_len,
	input wire fsab_data_t fsabo_data,
	input wire fsab_mask_t fsabo_mask,
	output logic fsabo_credit,
	output logic fsabi_valid,
	output fsab_did_t fsabi_did,
	output fsab_did_t fsabi_subdid,
	output fsab_data_t fsabi_data
);
	fsab_req_if req_bus ();	// Decode to execute
	fsab_rsp_if rsp_bus ();	// Execute to result

	fsab_req_decode u_decode (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.fsabo_valid (fsabo_valid),
		.fsabo_mode (fsabo_mode),
		.fsabo_did (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr (fsabo_addr),
		.fsabo_len (fsabo_len),
		.fsabo_data (fsabo_data),
		.fsabo_mask (fsabo_mask),
		.req (req_bus.decode)
	);

	fsab_mem_execute u_execute (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.req (req_bus.execute),
		.rsp (rsp_bus.execute),
		.fsabo_credit (fsabo_credit)
	);

	fsab_rsp_result u_result (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.rsp (rsp_bus.result),
		.fsabi_valid (fsabi_valid),
		.fsabi_did (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data (fsabi_data)
	);

endmodule

`default_nettype wire

//--- verif/tb_fsab_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsab_mem_defines.svh"

module tb_fsab_mem import fsab_mem_pkg::*; ();
	localparam int WAIT_LIMIT = 500;	// Cycles per wait loop
	localparam int WORDS = 2 ** `MEM_WORDS_LOG2;
	localparam int EXP_AW = 10;
	localparam int EXP_W = 1 + 2 * $bits(fsab_did_t) + $bits(fsab_data_t);

	logic clk0_tb;
	logic rst0_tb;
	logic fsabo_valid;
	fsab_mode_t fsabo_mode;
	fsab_did_t fsabo_did, fsabo_subdid;
	fsab_addr_t fsabo_addr;
	fsab_len_t fsabo_len;
	fsab_data_t fsabo_data;
	fsab_mask_t fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	fsab_did_t fsabi_did, fsabi_subdid;
	fsab_data_t fsabi_data;

	fsab_data_t sb_mem [WORDS];	// Scoreboard copy of the memory
	logic [EXP_W-1:0] exp_mem [2**EXP_AW];	// Expected beats: last, did, subdid, data
	logic [EXP_AW-1:0] exp_wr, exp_rd;
	logic exp_avail, exp_last;
	fsab_did_t exp_did, exp_subdid;
	fsab_data_t exp_data;
	int sent, returned, credits_held;
	logic req_seen;	// Set by the first request
	logic [31:0] lfsr_state;
	int value_errors, protocol_errors, timeout_errors;

	fsab_mem_top uut (.*);

	initial begin
		clk0_tb = 1'b0;
		forever #4 clk0_tb = ~clk0_tb;
	end

	assign credits_held = `FSAB_INITIAL_CREDITS - sent + returned;
	assign exp_avail = (exp_wr != exp_rd);
	assign {exp_last, exp_did, exp_subdid, exp_data} = exp_mem[exp_rd];

	// Retire one expected beat per fsabi beat, count credit pulses
	always @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			exp_rd <= '0;
			returned <= 0;
		end else begin
			if (fsabi_valid && exp_avail)
				exp_rd <= exp_rd + EXP_AW'(1);
			if (fsabo_credit)
				returned <= returned + 1;
		end
	end

	credit_quiet_after_reset: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		!req_seen |-> !fsabo_credit)
		else begin
			$display("** Error: fsabo_credit expected %h got %h", 1'b0, fsabo_credit);
			value_errors++;
		end

	rsp_quiet_after_reset: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		!req_seen |-> !fsabi_valid)
		else begin
			$display("** Error: fsabi_valid expected %h got %h", 1'b0, fsabi_valid);
			value_errors++;
		end

	rsp_was_expected: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid |-> exp_avail)
		else begin
			$display("Response beat on fsabi while no read beat was outstanding");
			protocol_errors++;
		end

	rsp_data_match: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid && exp_avail |-> fsabi_data == exp_data)
		else begin
			$display("** Error: fsabi_data expected %h got %h", exp_data, fsabi_data);
			value_errors++;
		end

	rsp_did_match: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid && exp_avail |-> fsabi_did == exp_did)
		else begin
			$display("** Error: fsabi_did expected %h got %h", exp_did, fsabi_did);
			value_errors++;
		end

	rsp_subdid_match: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid && exp_avail |-> fsabi_subdid == exp_subdid)
		else begin
			$display("** Error: fsabi_subdid expected %h got %h", exp_subdid, fsabi_subdid);
			value_errors++;
		end

	// A response leaves on consecutive cycles
	rsp_burst_unbroken: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid && exp_avail && !exp_last |=> fsabi_valid)
		else begin
			$display("Read response broke off before its last beat");
			protocol_errors++;
		end

	credit_single_cycle: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		fsabo_credit |=> !fsabo_credit)
		else begin
			$display("Credit pulse lasted longer than one cycle");
			protocol_errors++;
		end

	credit_count_in_range: assert property (@(negedge clk0_tb) disable iff (!rst0_tb)
		credits_held >= 0 && credits_held <= `FSAB_INITIAL_CREDITS)
		else begin
			$display("Master credit count left its range, now %0d", credits_held);
			protocol_errors++;
		end

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic end_run();
		$display("Errors: %0d value, %0d protocol, %0d timeout", value_errors,
			protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic wait_credit();
		int cycles;
		cycles = 0;
		while (credits_held == 0 && cycles < WAIT_LIMIT) begin
			@(posedge clk0_tb);
			#1;
			cycles++;
		end
		if (credits_held == 0) begin
			$display("Timed out waiting for the DUT to return a credit");
			timeout_errors++;
			end_run();
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((credits_held != `FSAB_INITIAL_CREDITS || exp_avail) && cycles < WAIT_LIMIT) begin
			@(posedge clk0_tb);
			#1;
			cycles++;
		end
		if (credits_held != `FSAB_INITIAL_CREDITS || exp_avail) begin
			$display("Timed out waiting for read responses and credits to come back");
			timeout_errors++;
			end_run();
		end
	endtask

	task automatic send_write(input fsab_addr_t addr, input fsab_len_t len,
		input fsab_did_t did, input fsab_did_t subdid, input logic full_mask);
		mem_index_t idx;
		fsab_data_t d;
		fsab_mask_t m;
		int n;
		int k;
		int b;
		wait_credit();
		idx = addr[3 +: `MEM_WORDS_LOG2];
		n = int'(len);
		sent++;
		req_seen = 1'b1;
		for (k = 0; k < n; k++) begin
			d = rand_bits(64);
			m = full_mask ? '1 : fsab_mask_t'(rand_bits(8));
			for (b = 0; b < $bits(fsab_mask_t); b++)
				if (m[b])
					sb_mem[idx][8*b +: 8] = d[8*b +: 8];
			fsabo_valid = 1'b1;
			fsabo_mode = FSAB_WRITE;
			fsabo_did = did;
			fsabo_subdid = subdid;
			fsabo_addr = addr;
			fsabo_len = len;
			fsabo_data = d;
			fsabo_mask = m;
			idx++;
			@(posedge clk0_tb);
			#1;
		end
		fsabo_valid = 1'b0;
	endtask

	task automatic send_read(input fsab_addr_t addr, input fsab_len_t len,
		input fsab_did_t did, input fsab_did_t subdid);
		mem_index_t idx;
		logic last;
		int n;
		int k;
		wait_credit();
		idx = addr[3 +: `MEM_WORDS_LOG2];
		n = int'(len);
		for (k = 0; k < n; k++) begin
			last = (k == n - 1);
			exp_mem[exp_wr] = {last, did, subdid, sb_mem[idx]};	// Beat k is word at addr + 8k
			exp_wr++;
			idx++;
		end
		sent++;
		req_seen = 1'b1;
		fsabo_valid = 1'b1;
		fsabo_mode = FSAB_READ;
		fsabo_did = did;
		fsabo_subdid = subdid;
		fsabo_addr = addr;
		fsabo_len = len;
		fsabo_data = '0;
		fsabo_mask = '0;
		@(posedge clk0_tb);
		#1;
		fsabo_valid = 1'b0;
	endtask

	initial begin
		fsab_addr_t a;
		fsab_len_t n;
		fsab_did_t d, s;
		logic is_write;
		int i;
		rst0_tb = 1'b0;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		lfsr_state = 32'hdcc;
		exp_wr = '0;
		sent = 0;
		req_seen = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		repeat (4) @(posedge clk0_tb);
		#1;
		rst0_tb = 1'b1;
		repeat (6) @(posedge clk0_tb);	// Outputs stay low while idle
		#1;

		a = fsab_addr_t'(rand_bits(32));	// Full-mask write then read back
		send_write(a, fsab_len_t'(4), 4'h3, 4'h9, 1'b1);
		send_read(a, fsab_len_t'(4), 4'h5, 4'ha);

		// Every word gets a known value before masked writes
		for (i = 0; i < WORDS / `FSAB_LEN_MAX; i++)
			send_write(fsab_addr_t'(i * 64), fsab_len_t'(`FSAB_LEN_MAX), 4'h1, 4'h0, 1'b1);

		a = fsab_addr_t'(rand_bits(32));	// Masked write keeps old bytes
		send_write(a, fsab_len_t'(5), 4'h2, 4'h4, 1'b0);
		send_read(a, fsab_len_t'(5), 4'h6, 4'h7);

		for (i = 0; i < 60; i++) begin
			a = fsab_addr_t'(rand_bits(32));
			n = fsab_len_t'(rand_bits(3) + 1);
			d = fsab_did_t'(rand_bits(4));
			s = fsab_did_t'(rand_bits(4));
			is_write = (rand_bits(1) != 64'd0);
			if (is_write)
				send_write(a, n, d, s, 1'b0);
			else
				send_read(a, n, d, s);
		end
		wait_drained();

		// Four mixed requests back to back, all credits in hand
		for (i = 0; i < `FSAB_INITIAL_CREDITS; i++) begin
			a = fsab_addr_t'(rand_bits(32));
			n = fsab_len_t'(rand_bits(3) + 1);
			d = fsab_did_t'(i);
			s = fsab_did_t'(rand_bits(4));
			if (i % 2 == 0)
				send_write(a, n, d, s, 1'b0);
			else
				send_read(a, n, d, s);
		end
		wait_drained();
		repeat (2) @(posedge clk0_tb);
		end_run();
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/fsab_mem_pkg.sv
source/fsab_mem_if.sv
source/fsab_req_decode.sv
source/fsab_mem_execute.sv
source/fsab_rsp_result.sv
source/fsab_mem_top.sv
verif/tb_fsab_mem.sv

//--- run.sh
#!/bin/sh
# Build and run the FSAB memory slave testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_fsab_mem \
	-f project.f

./obj_dir/Vtb_fsab_mem > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "run.sh: testbench reported failure"
	exit 1
fi
exit 0
